// ==== hw/cpu_macros.svh ====
// cpu width and depth macros
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data path
`define CPU_DATA_W      8    // acc, registers and memory bytes
`define CPU_NREGS       16   // r0 doubles as the accumulator
`define CPU_REG_AW      4    // register index bits

// program side
`define CPU_PC_W        8    // program counter bits
`define CPU_IMEM_DEPTH  256  // one word per pc value

// instruction format
`define CPU_INSTR_W     9    // opcode over operand
`define CPU_OP_W        4    // upper field
`define CPU_OPR_W       5    // lower field

// data memory
`define CPU_DMEM_DEPTH  32   // addressed by the full operand

`endif

// ==== hw/cpu_pkg.sv ====
// cpu shared types
package cpu_pkg;

  // instruction set, upper 4 bits of the instruction word
  typedef enum logic [3:0] {
    OP_ADD  = 4'h0,  // acc += r[opr], carry to sc
    OP_SUB  = 4'h1,  // acc -= r[opr], borrow to sc
    OP_AND  = 4'h2,
    OP_XOR  = 4'h3,
    OP_SHL  = 4'h4,  // through sc
    OP_SHR  = 4'h5,  // through sc
    OP_PAR  = 4'h6,  // pari = ^acc
    OP_LDI  = 4'h7,  // acc = const table
    OP_LD   = 4'h8,
    OP_ST   = 4'h9,
    OP_MOVA = 4'ha,  // r[opr] = acc
    OP_MOVR = 4'hb,  // acc = r[opr]
    OP_BSC  = 4'hc,
    OP_BPA  = 4'hd,
    OP_CLF  = 4'he,
    OP_HALT = 4'hf
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_PASS   // operand b straight through
  } alu_op_e;

  // accumulator write source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_CONST,
    WB_MEM,
    WB_REG
  } wb_sel_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_HALT
  } run_state_e;

endpackage

// ==== hw/ctrl_if.sv ====
// decoded control bundle
`timescale 1ns/1ps
`include "cpu_macros.svh"

interface ctrl_if import cpu_pkg::*; ();

  alu_op_e               alu_op;        // alu function
  logic                  b_from_const;  // b operand from constant table
  wb_sel_e               wb_sel;        // acc write source
  logic                  acc_we;        // r0 write
  logic                  reg_we;        // r[opr] write, mova only
  logic                  mem_we;        // dmem[opr] write
  logic                  sc_upd;        // load sc from alu
  logic                  pari_upd;      // load pari from acc
  logic                  flag_clr;      // clear both flags
  logic [`CPU_OPR_W-1:0] opr;           // raw operand field

  // decoder drives everything
  modport dec (
    output alu_op, b_from_const, wb_sel,
    output acc_we, reg_we, mem_we,
    output sc_upd, pari_upd, flag_clr,
    output opr
  );

  // alu and flag side
  modport exe (
    input alu_op, b_from_const,
    input sc_upd, pari_upd, flag_clr,
    input opr
  );

  // writeback, register file and dmem
  modport res (
    input wb_sel, acc_we, reg_we, mem_we,
    input opr
  );

endinterface

// ==== hw/fetch_unit.sv ====
// instruction fetch and run control
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit import cpu_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,      // one-cycle pulse
  input  logic                    branch,     // taken branch from decode
  input  logic                    halt,       // halt seen by decode
  input  logic [`CPU_OPR_W-1:0]   opr,        // branch table index
  input  logic                    prog_we,    // program write strobe
  input  logic [`CPU_PC_W-1:0]    prog_addr,
  input  logic [`CPU_INSTR_W-1:0] prog_data,
  output logic [`CPU_INSTR_W-1:0] instr,
  output logic                    running,
  output logic                    done
);

  run_state_e              state;
  logic [`CPU_PC_W-1:0]    pc;
  logic [`CPU_PC_W-1:0]    target;   // from branch table
  logic [`CPU_INSTR_W-1:0] imem [`CPU_IMEM_DEPTH];

  // branch table, entry k sits at 8*k
  function automatic logic [`CPU_PC_W-1:0] branch_target(input logic [3:0] k);
    branch_target = `CPU_PC_W'(k) << 3;
  endfunction

  assign target  = branch_target(opr[3:0]);  // upper operand bit ignored
  assign instr   = imem[pc];                 // async read
  assign running = (state == ST_RUN);
  assign done    = (state == ST_HALT);       // level until next start

  // run state and pc
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      pc    <= '0;
    end else begin
      case (state)
        ST_IDLE, ST_HALT: begin
          if (start) begin
            state <= ST_RUN;
            pc    <= '0;                     // always from the top
          end
        end
        ST_RUN: begin
          if (halt) begin
            state <= ST_HALT;                // pc parks on the halt
          end else if (branch) begin
            pc <= target;
          end else begin
            pc <= pc + 1'b1;                 // wraps at the end
          end
        end
        default: state <= ST_IDLE;           // unused encoding
      endcase
    end
  end

  // program load port, locked out while running
  always_ff @(posedge clk) begin
    if (prog_we && !running) begin
      imem[prog_addr] <= prog_data;
    end
  end

endmodule

// ==== hw/decode_unit.sv ====
// opcode decoder
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_unit import cpu_pkg::*; (
  input  logic [`CPU_INSTR_W-1:0] instr,
  input  logic                    running,  // enables gated on this
  input  logic                    sc_q,     // for bsc
  input  logic                    pari_q,   // for bpa
  ctrl_if.dec                     ctl,
  output logic                    branch,
  output logic                    halt
);

  opcode_e op;

  assign op      = opcode_e'(instr[`CPU_INSTR_W-1 -: `CPU_OP_W]);
  assign ctl.opr = instr[`CPU_OPR_W-1:0];

  // alu function, pass for everything that is not arithmetic
  always_comb begin
    case (op)
      OP_ADD:  ctl.alu_op = ALU_ADD;
      OP_SUB:  ctl.alu_op = ALU_SUB;
      OP_AND:  ctl.alu_op = ALU_AND;
      OP_XOR:  ctl.alu_op = ALU_XOR;
      OP_SHL:  ctl.alu_op = ALU_SHL;
      OP_SHR:  ctl.alu_op = ALU_SHR;
      default: ctl.alu_op = ALU_PASS;   // ldi lands here
    endcase
  end

  // enables and flow control
  always_comb begin
    ctl.b_from_const = 1'b0;
    ctl.wb_sel       = WB_ALU;
    ctl.acc_we       = 1'b0;
    ctl.reg_we       = 1'b0;
    ctl.mem_we       = 1'b0;
    ctl.sc_upd       = 1'b0;
    ctl.pari_upd     = 1'b0;
    ctl.flag_clr     = 1'b0;
    branch           = 1'b0;
    halt             = 1'b0;
    if (running) begin                  // idle or halted, all quiet
      case (op)
        OP_ADD, OP_SUB, OP_SHL, OP_SHR: begin
          ctl.acc_we = 1'b1;
          ctl.sc_upd = 1'b1;            // carry, borrow or bit out
        end
        OP_AND, OP_XOR: ctl.acc_we = 1'b1;
        OP_PAR:  ctl.pari_upd = 1'b1;   // acc untouched
        OP_LDI: begin
          ctl.b_from_const = 1'b1;
          ctl.wb_sel       = WB_CONST;
          ctl.acc_we       = 1'b1;
        end
        OP_LD: begin
          ctl.wb_sel = WB_MEM;
          ctl.acc_we = 1'b1;
        end
        OP_ST:   ctl.mem_we = 1'b1;
        OP_MOVA: ctl.reg_we = 1'b1;
        OP_MOVR: begin
          ctl.wb_sel = WB_REG;
          ctl.acc_we = 1'b1;
        end
        OP_BSC:  branch = sc_q;         // taken on set flag
        OP_BPA:  branch = pari_q;
        OP_CLF:  ctl.flag_clr = 1'b1;
        OP_HALT: halt = 1'b1;
      endcase
    end
  end

endmodule

// ==== hw/execute_unit.sv ====
// alu, constant table and flags
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  ctrl_if.exe                    ctl,
  input  logic [`CPU_DATA_W-1:0] acc,       // operand a, always r0
  input  logic [`CPU_DATA_W-1:0] reg_b,     // r[opr]
  output logic [`CPU_DATA_W-1:0] alu_rslt,
  output logic                   sc_q,      // shift/carry flag
  output logic                   pari_q     // parity flag
);

  localparam int NCONST = 1 << `CPU_OPR_W;  // one entry per operand value

  logic [`CPU_DATA_W-1:0] ctab [NCONST];    // constant table
  logic [`CPU_DATA_W-1:0] op_b;
  logic [`CPU_DATA_W:0]   wide;             // msb is carry/borrow/bit out
  logic                   sc_d;
  logic                   pari_d;

  // entry i = 7*i + 3, wrapped to a byte
  always_comb begin
    for (int i = 0; i < NCONST; i++) begin
      ctab[i] = `CPU_DATA_W'(7 * i + 3);
    end
  end

  assign op_b = ctl.b_from_const ? ctab[ctl.opr] : reg_b;

  // alu proper
  always_comb begin
    wide = '0;
    case (ctl.alu_op)
      ALU_ADD: wide = {1'b0, acc} + {1'b0, op_b};   // bit 8 carry
      ALU_SUB: wide = {1'b0, acc} - {1'b0, op_b};   // bit 8 set when acc < b
      ALU_AND: wide[`CPU_DATA_W-1:0] = acc & op_b;
      ALU_XOR: wide[`CPU_DATA_W-1:0] = acc ^ op_b;
      ALU_SHL: wide = {acc, sc_q};                  // msb out, sc in at lsb
      ALU_SHR: begin
        // lsb out to the top bit, sc shifted in at msb
        wide = {acc[0], sc_q, acc[`CPU_DATA_W-1:1]};
      end
      default: wide[`CPU_DATA_W-1:0] = op_b;        // pass, ldi path
    endcase
  end

  assign alu_rslt = wide[`CPU_DATA_W-1:0];
  assign sc_d     = wide[`CPU_DATA_W];
  assign pari_d   = ^acc;                          // parity of acc as it stands

  // flag registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sc_q   <= 1'b0;
      pari_q <= 1'b0;
    end else if (ctl.flag_clr) begin  // clf wins
      sc_q   <= 1'b0;
      pari_q <= 1'b0;
    end else begin
      if (ctl.sc_upd) begin
        sc_q <= sc_d;
      end
      if (ctl.pari_upd) begin
        pari_q <= pari_d;
      end
    end
  end

endmodule

// ==== hw/result_unit.sv ====
// register file, data memory and writeback
`timescale 1ns/1ps
`include "cpu_macros.svh"

module result_unit import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  ctrl_if.res                    ctl,
  input  logic [`CPU_DATA_W-1:0] alu_rslt,
  input  logic [`CPU_REG_AW-1:0] dbg_addr,
  output logic [`CPU_DATA_W-1:0] acc,       // r0
  output logic [`CPU_DATA_W-1:0] reg_b,     // r[opr]
  output logic [`CPU_DATA_W-1:0] dbg_data
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
  logic [`CPU_DATA_W-1:0] dmem [`CPU_DMEM_DEPTH];
  logic [`CPU_REG_AW-1:0] ridx;    // low operand bits
  logic [`CPU_DATA_W-1:0] mem_q;
  logic [`CPU_DATA_W-1:0] acc_d;   // next accumulator

  assign ridx     = ctl.opr[`CPU_REG_AW-1:0];
  assign acc      = regs[0];
  assign reg_b    = regs[ridx];
  assign mem_q    = dmem[ctl.opr];   // async read
  assign dbg_data = regs[dbg_addr];

  // acc source
  always_comb begin
    case (ctl.wb_sel)
      WB_ALU:   acc_d = alu_rslt;
      WB_CONST: acc_d = alu_rslt;    // constant comes through alu pass
      WB_MEM:   acc_d = mem_q;
      WB_REG:   acc_d = reg_b;       // movr
    endcase
  end

  // register file, one write per cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctl.acc_we) begin
      regs[0] <= acc_d;
    end else if (ctl.reg_we) begin
      regs[ridx] <= acc;             // mova copies acc out
    end
  end

  // data memory, st only
  always_ff @(posedge clk) begin
    if (ctl.mem_we) begin
      dmem[ctl.opr] <= acc;
    end
  end

endmodule

// ==== hw/cpu_top.sv ====
// accumulator cpu top level
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,       // one-cycle pulse
  input  logic                    prog_we,     // program write strobe
  input  logic [`CPU_PC_W-1:0]    prog_addr,
  input  logic [`CPU_INSTR_W-1:0] prog_data,
  input  logic [`CPU_REG_AW-1:0]  dbg_addr,    // register to peek
  output logic                    done,
  output logic [`CPU_DATA_W-1:0]  dbg_data,
  output logic                    flags_sc,
  output logic                    flags_pari
);

  logic [`CPU_INSTR_W-1:0] instr;
  logic                    running;
  logic                    branch;
  logic                    halt;
  logic [`CPU_DATA_W-1:0]  acc;
  logic [`CPU_DATA_W-1:0]  reg_b;
  logic [`CPU_DATA_W-1:0]  alu_rslt;

  ctrl_if ctl ();   // decoded control

  fetch_unit u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .branch    (branch),
    .halt      (halt),
    .opr       (ctl.opr),      // branch table index
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .instr     (instr),
    .running   (running),
    .done      (done)
  );

  decode_unit u_decode (
    .instr   (instr),
    .running (running),
    .sc_q    (flags_sc),       // flags come straight off the execute regs
    .pari_q  (flags_pari),
    .ctl     (ctl.dec),
    .branch  (branch),
    .halt    (halt)
  );

  execute_unit u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctl      (ctl.exe),
    .acc      (acc),
    .reg_b    (reg_b),
    .alu_rslt (alu_rslt),
    .sc_q     (flags_sc),
    .pari_q   (flags_pari)
  );

  result_unit u_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .ctl      (ctl.res),
    .alu_rslt (alu_rslt),
    .dbg_addr (dbg_addr),
    .acc      (acc),
    .reg_b    (reg_b),
    .dbg_data (dbg_data)
  );

endmodule

// ==== test/cpu_properties.sv ====
// run control assertions
`timescale 1ns/1ps

module cpu_properties (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic done,
  input logic running,
  input logic acc_we,
  input logic reg_we,
  input logic mem_we
);

  int unsigned fail_cnt = 0;   // failed assertions so far

  // done is a level, only a start pulse takes it down
  a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(done) |-> $past(start))
    else begin
      $error("done dropped with no start pulse before it");
      fail_cnt++;
    end

  // idle or halted core writes nothing
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !running |-> !(acc_we || reg_we || mem_we))
    else begin
      $error("register or memory write while the core is not running");
      fail_cnt++;
    end

  a_start_clears: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> !done)   // one cycle after start
    else begin
      $error("done still high one cycle after start");
      fail_cnt++;
    end

endmodule

bind cpu_top cpu_properties u_props (
  .clk     (clk),
  .rst_n   (rst_n),
  .start   (start),
  .done    (done),
  .running (running),
  .acc_we  (ctl.acc_we),   // straight off the control bundle
  .reg_we  (ctl.reg_we),
  .mem_we  (ctl.mem_we)
);

// ==== test/cpu_tb.sv ====
// accumulator cpu testbench
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int NUM_TESTS = 6;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    start;
  logic                    prog_we;
  logic [`CPU_PC_W-1:0]    prog_addr;
  logic [`CPU_INSTR_W-1:0] prog_data;
  logic [`CPU_REG_AW-1:0]  dbg_addr;
  logic                    done;
  logic [`CPU_DATA_W-1:0]  dbg_data;
  logic                    flags_sc;
  logic                    flags_pari;

  logic [`CPU_INSTR_W-1:0] prog_buf [`CPU_IMEM_DEPTH];  // staged program
  int     wr_pos;     // next slot to fill
  int     prog_len;   // one past the highest slot used
  int     errors;
  int     checks;
  integer seed = 32'h240b4aaa;
  string  cur_test;
  string  names [NUM_TESTS] = '{"consts", "arith", "logic", "memory", "branch", "restart"};

  cpu_top dut0 (.*);

  always #10 clk = ~clk;   // 20 ns

  // whole run budget, 400 cycles a test
  initial begin
    repeat (NUM_TESTS * 400) @(posedge clk);
    $display("timeout: done never rose within %0d cycles", NUM_TESTS * 400);
    $display("Simulation failed");
    $finish;
  end

  // table entry i is 7*i + 3, kept to a byte
  function automatic logic [`CPU_DATA_W-1:0] const_entry(input int i);
    const_entry = (7 * i + 3) % 256;
  endfunction

  function automatic int rand_index(input int n);
    rand_index = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic new_prog();
    for (int a = 0; a < `CPU_IMEM_DEPTH; a++) begin
      prog_buf[a] = {OP_HALT, `CPU_OPR_W'(0)};   // unused slots halt
    end
    wr_pos   = 0;
    prog_len = 0;
  endtask

  task automatic put(input opcode_e op, input int opr);
    prog_buf[wr_pos] = {op, `CPU_OPR_W'(opr)};
    wr_pos++;
    if (wr_pos > prog_len) prog_len = wr_pos;
  endtask

  // staged words plus the trailing halt
  task automatic load_prog();
    for (int a = 0; a <= prog_len; a++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= a[`CPU_PC_W-1:0];
      prog_data <= prog_buf[a];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  task automatic run_prog();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    while (done !== 1'b1) @(negedge clk);   // done comes up once halted
  endtask

  task automatic load_run();
    load_prog();
    run_prog();
  endtask

  task automatic read_reg(input int idx, output logic [`CPU_DATA_W-1:0] val);
    @(posedge clk);
    dbg_addr <= idx[`CPU_REG_AW-1:0];
    @(negedge clk);
    val = dbg_data;
  endtask

  task automatic check_data(input string what, input logic [`CPU_DATA_W-1:0] exp,
                            input logic [`CPU_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected 0x%02h, actual 0x%02h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
    end
  endtask

  // clf, b = const j into r1, acc = const i, then op on r1
  task automatic alu_case(input opcode_e op, input int i, input int j, input int reps,
                          input logic [`CPU_DATA_W-1:0] exp_acc, input logic exp_sc);
    logic [`CPU_DATA_W-1:0] v;
    new_prog();
    put(OP_CLF, 0);
    put(OP_LDI, j);
    put(OP_MOVA, 1);
    put(OP_LDI, i);
    repeat (reps) put(op, 1);
    load_run();
    read_reg(0, v);
    check_data($sformatf("%s %0d,%0d acc", op.name(), i, j), exp_acc, v);
    check_flag($sformatf("%s %0d,%0d sc", op.name(), i, j), exp_sc, flags_sc);
  endtask

  task automatic test_consts();
    int idx [8];
    logic [`CPU_DATA_W-1:0] v;
    new_prog();
    for (int r = 1; r < 8; r++) begin
      idx[r] = rand_index(32);
      put(OP_LDI, idx[r]);
      put(OP_MOVA, r);
    end
    load_run();
    for (int r = 1; r < 8; r++) begin
      read_reg(r, v);
      check_data($sformatf("r%0d", r), const_entry(idx[r]), v);
    end
    check_flag("done held", 1'b1, done);   // still a level after the reads
  endtask

  task automatic test_arith();
    int i;
    int j;
    int a;
    int b;
    for (int n = 0; n < 4; n++) begin
      i = rand_index(32);
      j = rand_index(32);
      if (n < 2) begin   // 220 and 213 both ways, carry then borrow
        i = 31 - n;
        j = 30 + n;
      end
      a = const_entry(i);
      b = const_entry(j);
      alu_case(OP_ADD, i, j, 1, `CPU_DATA_W'(a + b), a + b > 255);
      alu_case(OP_SUB, i, j, 1, `CPU_DATA_W'(a - b), a < b);
    end
  endtask

  task automatic test_logic();
    int i;
    int j;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] x;
    i = rand_index(32);
    j = rand_index(32);
    a = const_entry(i);
    alu_case(OP_AND, i, j, 1, a & const_entry(j), 1'b0);
    alu_case(OP_XOR, i, j, 1, a ^ const_entry(j), 1'b0);
    x = a << 1;   // first shift brings in the cleared sc
    alu_case(OP_SHL, i, j, 2, {x[6:0], a[7]}, x[7]);
    x = a >> 1;
    alu_case(OP_SHR, i, j, 2, {a[0], x[7:1]}, x[0]);
    alu_case(OP_PAR, i, j, 1, a, 1'b0);
    check_flag("par", $countones(a) % 2, flags_pari);
    new_prog();
    put(OP_LDI, 31);
    put(OP_PAR, 0);
    put(OP_MOVA, 1);
    put(OP_ADD, 1);   // doubles the constant
    load_run();
    check_flag("sc set", 2 * const_entry(31) > 255, flags_sc);
    check_flag("pari set", $countones(const_entry(31)) % 2, flags_pari);
    new_prog();
    put(OP_CLF, 0);
    load_run();
    check_flag("clf sc", 1'b0, flags_sc);
    check_flag("clf pari", 1'b0, flags_pari);
  endtask

  task automatic test_memory();
    int base;
    int idx [4];
    logic [`CPU_DATA_W-1:0] v;
    base = rand_index(32);
    new_prog();
    for (int k = 0; k < 4; k++) begin
      idx[k] = rand_index(32);
      put(OP_LDI, idx[k]);
      put(OP_ST, (base + 9 * k) % 32);   // four distinct bytes
    end
    put(OP_LDI, 0);   // clobber acc
    for (int k = 0; k < 4; k++) begin
      put(OP_LD, (base + 9 * k) % 32);
      put(OP_MOVA, k + 1);
    end
    load_run();
    for (int k = 0; k < 4; k++) begin
      read_reg(k + 1, v);
      check_data($sformatf("dmem[%0d]", (base + 9 * k) % 32), const_entry(idx[k]), v);
    end
  endtask

  // marker r10 at the fall-through, r11 at 8*k
  task automatic branch_case(input opcode_e op, input logic flag, input int opr);
    int m;
    logic [`CPU_DATA_W-1:0] ft;
    logic [`CPU_DATA_W-1:0] tk;
    m = 1 + rand_index(31);   // never entry 0
    new_prog();
    put(OP_LDI, 0);
    put(OP_MOVA, 10);
    put(OP_MOVA, 11);
    put(OP_CLF, 0);
    if (flag) begin
      put(OP_LDI, 31);   // 220, odd parity
      put(OP_MOVA, 1);
      put(op == OP_BSC ? OP_ADD : OP_PAR, 1);
    end
    put(OP_LDI, m);
    put(op, opr);
    put(OP_MOVA, 10);
    wr_pos = 8 * (opr % 16);   // low 4 bits pick the target
    put(OP_MOVA, 11);
    load_run();
    read_reg(10, ft);
    read_reg(11, tk);
    check_data($sformatf("%s %0b fall-through", op.name(), flag),
               flag ? const_entry(0) : const_entry(m), ft);
    check_data($sformatf("%s %0b target", op.name(), flag),
               flag ? const_entry(m) : const_entry(0), tk);
  endtask

  task automatic test_branch();
    branch_case(OP_BSC, 1'b1, 2);
    branch_case(OP_BSC, 1'b0, 3);
    branch_case(OP_BPA, 1'b1, 18);   // operand bit 4 set
    branch_case(OP_BPA, 1'b0, 3);
  endtask

  // each start adds the step to r5 once
  task automatic test_restart();
    int i0;
    logic [`CPU_DATA_W-1:0] v;
    i0 = rand_index(32);
    new_prog();
    put(OP_LDI, 0);
    put(OP_MOVA, 6);   // step
    put(OP_LDI, i0);
    put(OP_MOVA, 5);   // counter seed
    load_run();
    new_prog();
    put(OP_MOVR, 5);
    put(OP_ADD, 6);
    put(OP_MOVA, 5);
    load_prog();
    for (int n = 1; n <= 4; n++) begin
      run_prog();
      read_reg(5, v);
      check_data($sformatf("r5 after run %0d", n),
                 `CPU_DATA_W'(const_entry(i0) + n * const_entry(0)), v);
    end
  endtask

  initial begin
    int errs_before;
    rst_n     <= 1'b0;
    start     <= 1'b0;
    prog_we   <= 1'b0;
    prog_addr <= '0;
    prog_data <= '0;
    dbg_addr  <= '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test    = names[t];
      errs_before = errors;
      case (t)
        0: test_consts();
        1: test_arith();
        2: test_logic();
        3: test_memory();
        4: test_branch();
        default: test_restart();
      endcase
      $display("test %-8s %s, %0d errors", cur_test,
               (errors == errs_before) ? "ok" : "FAILED", errors - errs_before);
    end
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             NUM_TESTS, checks, errors, dut0.u_props.fail_cnt);
    if (errors == 0 && dut0.u_props.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/ctrl_if.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/result_unit.sv
hw/cpu_top.sv
test/cpu_properties.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: acc_cpu

export_include_dirs:
  - hw

sources:
  - files:
      - hw/cpu_pkg.sv
      - hw/ctrl_if.sv
      - hw/fetch_unit.sv
      - hw/decode_unit.sv
      - hw/execute_unit.sv
      - hw/result_unit.sv
      - hw/cpu_top.sv
  - target: test
    files:
      - test/cpu_properties.sv
      - test/cpu_tb.sv
